// ==== hdl/dev_tables.sv ====
// Hardware always wins a table; software writes to DCT are acked and dropped
`timescale 1ns/1ps
`default_nettype none

module dev_tables (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  // Controller side, DAT
  input  logic                                         dat_rd_hw_i,
  input  logic [i3c_table_pkg::DAT_AW-1:0]             dat_idx_hw_i,
  output logic [i3c_table_pkg::DAT_DW-1:0]             dat_rdata_hw_o,
  // Controller side, DCT
  input  logic                                         dct_rd_hw_i,
  input  logic                                         dct_wr_hw_i,
  input  logic [i3c_table_pkg::DCT_AW-1:0]             dct_idx_hw_i,
  input  logic [i3c_table_pkg::DCT_DW-1:0]             dct_wdata_hw_i,
  output logic [i3c_table_pkg::DCT_DW-1:0]             dct_rdata_hw_o,
  // Software front end
  input  logic                                         dat_sw_req_i,
  input  logic                                         dct_sw_req_i,
  input  logic                                         sw_we_i,
  input  logic [i3c_table_pkg::DCT_AW-1:0]             sw_index_i,
  input  logic [$clog2(i3c_table_pkg::DCT_WORDS)-1:0]  sw_word_i,
  input  logic [i3c_csr_pkg::SW_DW-1:0]                sw_wdata_i,
  output logic                                         dat_sw_gnt_o,
  output logic                                         dct_sw_gnt_o,
  output logic                                         sw_rd_ack_o,
  output logic                                         sw_wr_ack_o,
  output logic [i3c_csr_pkg::SW_DW-1:0]                sw_rdata_o,
  // DAT RAM
  output logic                                         dat_ram_req_o,
  output logic                                         dat_ram_we_o,
  output logic [i3c_table_pkg::DAT_AW-1:0]             dat_ram_addr_o,
  output logic [i3c_table_pkg::DAT_DW-1:0]             dat_ram_wdata_o,
  output logic [i3c_table_pkg::DAT_DW-1:0]             dat_ram_wmask_o,
  input  logic [i3c_table_pkg::DAT_DW-1:0]             dat_ram_rdata_i,
  // DCT RAM
  output logic                                         dct_ram_req_o,
  output logic                                         dct_ram_we_o,
  output logic [i3c_table_pkg::DCT_AW-1:0]             dct_ram_addr_o,
  output logic [i3c_table_pkg::DCT_DW-1:0]             dct_ram_wdata_o,
  output logic [i3c_table_pkg::DCT_DW-1:0]             dct_ram_wmask_o,
  input  logic [i3c_table_pkg::DCT_DW-1:0]             dct_ram_rdata_i
);
  import i3c_table_pkg::*;
  import i3c_csr_pkg::*;

  logic sw_gnt;
  logic rd_s1, wr_s1;
  logic sel_dct_s1;
  logic [$clog2(DCT_WORDS)-1:0] word_s1;

  // Software only gets a table the controller is not using this cycle
  assign dat_sw_gnt_o = dat_sw_req_i && !dat_rd_hw_i;
  assign dct_sw_gnt_o = dct_sw_req_i && !dct_rd_hw_i && !dct_wr_hw_i;
  assign sw_gnt       = dat_sw_gnt_o || dct_sw_gnt_o;

  assign dat_rdata_hw_o = dat_ram_rdata_i;
  assign dct_rdata_hw_o = dct_ram_rdata_i;

  assign dat_ram_req_o = dat_rd_hw_i || dat_sw_gnt_o;
  assign dat_ram_we_o  = dat_sw_gnt_o && sw_we_i;

  // Software DAT writes touch only the 32-bit lane picked by the word number
  always_comb begin
    dat_ram_wdata_o = '0;
    dat_ram_wmask_o = '0;
    if (dat_rd_hw_i) begin
      dat_ram_addr_o  = dat_idx_hw_i;
      dat_ram_wmask_o = '1;
    end else begin
      dat_ram_addr_o = sw_index_i;
      for (int w = 0; w < DAT_WORDS; w++) begin
        if (sw_word_i == w) begin
          dat_ram_wmask_o[w*SW_DW +: SW_DW] = '1;
          dat_ram_wdata_o[w*SW_DW +: SW_DW] = sw_wdata_i;
        end
      end
    end
  end

  // DCT is only ever written whole by the controller
  assign dct_ram_req_o   = dct_rd_hw_i || dct_wr_hw_i || (dct_sw_gnt_o && !sw_we_i);
  assign dct_ram_we_o    = dct_wr_hw_i;
  assign dct_ram_addr_o  = (dct_rd_hw_i || dct_wr_hw_i) ? dct_idx_hw_i : sw_index_i;
  assign dct_ram_wdata_o = dct_wdata_hw_i;
  assign dct_ram_wmask_o = (dct_rd_hw_i || dct_wr_hw_i) ? '1 : '0;

  // Ack pipeline, stage 1 lines up with the RAM output
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_s1       <= 1'b0;
      wr_s1       <= 1'b0;
      sw_rd_ack_o <= 1'b0;
      sw_wr_ack_o <= 1'b0;
    end else begin
      rd_s1       <= sw_gnt && !sw_we_i;
      wr_s1       <= sw_gnt && sw_we_i;
      sw_rd_ack_o <= rd_s1;
      sw_wr_ack_o <= wr_s1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (sw_gnt) begin
      sel_dct_s1 <= dct_sw_gnt_o;
      word_s1    <= sw_word_i;
    end
  end

  // Registered word select, only moves on a software read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sw_rdata_o <= '0;
    end else if (rd_s1) begin
      if (sel_dct_s1) begin
        sw_rdata_o <= dct_ram_rdata_i[word_s1*SW_DW +: SW_DW];
      end else begin
        sw_rdata_o <= dat_ram_rdata_i[word_s1[$clog2(DAT_WORDS)-1:0]*SW_DW +: SW_DW];
      end
    end
  end

  // Controller never reads and writes DCT in the same cycle
  hw_dct_excl_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(dct_rd_hw_i && dct_wr_hw_i));

endmodule

`default_nettype wire

// ==== hdl/i3c_csr_pkg.sv ====
// Software window is 4 KB of word-aligned addresses; 0x400 to 0x7FF is unmapped and reads zero
`default_nettype none

package i3c_csr_pkg;

  localparam int unsigned SW_AW = 12;
  localparam int unsigned SW_DW = 32;

  // DAT takes 1 KB from the bottom, DCT the upper 2 KB
  localparam logic [SW_AW-1:0] DAT_BASE = 12'h000;
  localparam logic [SW_AW-1:0] DCT_BASE = 12'h800;

  typedef enum logic [1:0] {
    REG_DAT,
    REG_DCT,
    REG_NONE
  } csr_region_e;

  typedef enum logic [1:0] {
    FS_IDLE,
    FS_WAIT_GRANT,
    FS_WAIT_ACK
  } front_state_e;

endpackage

`default_nettype wire

// ==== hdl/i3c_table_pkg.sv ====
// Table sizes are fixed here; DAT and DCT entries must be whole multiples of 32-bit words
`default_nettype none

package i3c_table_pkg;

  // Device Address Table, 128 entries
  localparam int unsigned DAT_AW = 7;
  localparam int unsigned DAT_DW = 64;

  // Device Context Table, 128 entries
  localparam int unsigned DCT_AW = 7;
  localparam int unsigned DCT_DW = 128;

  // Software sees each entry as a run of 32-bit words
  localparam int unsigned DAT_WORDS = 2;
  localparam int unsigned DCT_WORDS = 4;

endpackage

`default_nettype wire

// ==== hdl/i3c_tables_top.sv ====
// Hardware reads return data one cycle later; software latency varies, so wait for sw_ack_o
`timescale 1ns/1ps
`default_nettype none

module i3c_tables_top (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // Controller side
  input  logic                              dat_rd_i,
  input  logic [i3c_table_pkg::DAT_AW-1:0]  dat_idx_i,
  output logic [i3c_table_pkg::DAT_DW-1:0]  dat_rdata_o,
  input  logic                              dct_rd_i,
  input  logic                              dct_wr_i,
  input  logic [i3c_table_pkg::DCT_AW-1:0]  dct_idx_i,
  input  logic [i3c_table_pkg::DCT_DW-1:0]  dct_wdata_i,
  output logic [i3c_table_pkg::DCT_DW-1:0]  dct_rdata_o,
  // Software register bus
  input  logic                              sw_req_i,
  input  logic                              sw_we_i,
  input  logic [i3c_csr_pkg::SW_AW-1:0]     sw_addr_i,
  input  logic [i3c_csr_pkg::SW_DW-1:0]     sw_wdata_i,
  output logic                              sw_ack_o,
  output logic [i3c_csr_pkg::SW_DW-1:0]     sw_rdata_o
);
  import i3c_table_pkg::*;
  import i3c_csr_pkg::*;

  // Front end to table block
  logic dat_sw_req, dct_sw_req, sw_we;
  logic [DCT_AW-1:0] sw_index;
  logic [$clog2(DCT_WORDS)-1:0] sw_word;
  logic [SW_DW-1:0] sw_wdata, sw_rdata;
  logic dat_sw_gnt, dct_sw_gnt, sw_rd_ack, sw_wr_ack;

  // Table block to RAMs
  logic dat_ram_req, dat_ram_we, dct_ram_req, dct_ram_we;
  logic [DAT_AW-1:0] dat_ram_addr;
  logic [DCT_AW-1:0] dct_ram_addr;
  logic [DAT_DW-1:0] dat_ram_wdata, dat_ram_wmask, dat_ram_rdata;
  logic [DCT_DW-1:0] dct_ram_wdata, dct_ram_wmask, dct_ram_rdata;

  table_csr_front u_front (
    .clk_i      (clk_i),      .rst_ni     (rst_ni),
    .sw_req_i   (sw_req_i),   .sw_we_i    (sw_we_i),
    .sw_addr_i  (sw_addr_i),  .sw_wdata_i (sw_wdata_i),
    .sw_ack_o   (sw_ack_o),   .sw_rdata_o (sw_rdata_o),
    .dat_req_o  (dat_sw_req), .dct_req_o  (dct_sw_req),
    .we_o       (sw_we),      .index_o    (sw_index),
    .word_o     (sw_word),    .wdata_o    (sw_wdata),
    .dat_gnt_i  (dat_sw_gnt), .dct_gnt_i  (dct_sw_gnt),
    .rd_ack_i   (sw_rd_ack),  .wr_ack_i   (sw_wr_ack),
    .rdata_i    (sw_rdata)
  );

  dev_tables u_tables (
    .clk_i           (clk_i),         .rst_ni          (rst_ni),
    .dat_rd_hw_i     (dat_rd_i),      .dat_idx_hw_i    (dat_idx_i),
    .dat_rdata_hw_o  (dat_rdata_o),
    .dct_rd_hw_i     (dct_rd_i),      .dct_wr_hw_i     (dct_wr_i),
    .dct_idx_hw_i    (dct_idx_i),     .dct_wdata_hw_i  (dct_wdata_i),
    .dct_rdata_hw_o  (dct_rdata_o),
    .dat_sw_req_i    (dat_sw_req),    .dct_sw_req_i    (dct_sw_req),
    .sw_we_i         (sw_we),         .sw_index_i      (sw_index),
    .sw_word_i       (sw_word),       .sw_wdata_i      (sw_wdata),
    .dat_sw_gnt_o    (dat_sw_gnt),    .dct_sw_gnt_o    (dct_sw_gnt),
    .sw_rd_ack_o     (sw_rd_ack),     .sw_wr_ack_o     (sw_wr_ack),
    .sw_rdata_o      (sw_rdata),
    .dat_ram_req_o   (dat_ram_req),   .dat_ram_we_o    (dat_ram_we),
    .dat_ram_addr_o  (dat_ram_addr),  .dat_ram_wdata_o (dat_ram_wdata),
    .dat_ram_wmask_o (dat_ram_wmask), .dat_ram_rdata_i (dat_ram_rdata),
    .dct_ram_req_o   (dct_ram_req),   .dct_ram_we_o    (dct_ram_we),
    .dct_ram_addr_o  (dct_ram_addr),  .dct_ram_wdata_o (dct_ram_wdata),
    .dct_ram_wmask_o (dct_ram_wmask), .dct_ram_rdata_i (dct_ram_rdata)
  );

  table_ram #(.AW(DAT_AW), .DW(DAT_DW)) u_dat_ram (
    .clk_i   (clk_i),         .rst_ni  (rst_ni),
    .req_i   (dat_ram_req),   .we_i    (dat_ram_we),
    .addr_i  (dat_ram_addr),  .wdata_i (dat_ram_wdata),
    .wmask_i (dat_ram_wmask), .rdata_o (dat_ram_rdata)
  );

  table_ram #(.AW(DCT_AW), .DW(DCT_DW)) u_dct_ram (
    .clk_i   (clk_i),         .rst_ni  (rst_ni),
    .req_i   (dct_ram_req),   .we_i    (dct_ram_we),
    .addr_i  (dct_ram_addr),  .wdata_i (dct_ram_wdata),
    .wmask_i (dct_ram_wmask), .rdata_o (dct_ram_rdata)
  );

endmodule

`default_nettype wire

// ==== hdl/table_csr_front.sv ====
// One software access at a time; a new sw_req_i before sw_ack_o is illegal and is not queued
`timescale 1ns/1ps
`default_nettype none

module table_csr_front (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic                                         sw_req_i,
  input  logic                                         sw_we_i,
  input  logic [i3c_csr_pkg::SW_AW-1:0]                sw_addr_i,
  input  logic [i3c_csr_pkg::SW_DW-1:0]                sw_wdata_i,
  output logic                                         sw_ack_o,
  output logic [i3c_csr_pkg::SW_DW-1:0]                sw_rdata_o,
  output logic                                         dat_req_o,
  output logic                                         dct_req_o,
  output logic                                         we_o,
  output logic [i3c_table_pkg::DCT_AW-1:0]             index_o,
  output logic [$clog2(i3c_table_pkg::DCT_WORDS)-1:0]  word_o,
  output logic [i3c_csr_pkg::SW_DW-1:0]                wdata_o,
  input  logic                                         dat_gnt_i,
  input  logic                                         dct_gnt_i,
  input  logic                                         rd_ack_i,
  input  logic                                         wr_ack_i,
  input  logic [i3c_csr_pkg::SW_DW-1:0]                rdata_i
);
  import i3c_csr_pkg::*;
  import i3c_table_pkg::*;

  front_state_e state_q, state_d;
  csr_region_e region_d, region_q, req_region;
  logic [DCT_AW-1:0] index_d, index_q;
  logic [$clog2(DCT_WORDS)-1:0] word_d, word_q;
  logic we_q;
  logic [SW_DW-1:0] wdata_q;
  logic granted;

  // Address decode, DCT checked first since it owns the whole upper half
  always_comb begin
    if (sw_addr_i[11] == DCT_BASE[11]) begin
      region_d = REG_DCT;
      index_d  = sw_addr_i[10:4];
      word_d   = sw_addr_i[3:2];
    end else if (sw_addr_i[11:10] == DAT_BASE[11:10]) begin
      region_d = REG_DAT;
      index_d  = sw_addr_i[9:3];
      word_d   = {1'b0, sw_addr_i[2]};
    end else begin
      region_d = REG_NONE;
      index_d  = '0;
      word_d   = '0;
    end
  end

  // In idle the request goes straight through so it can be granted in its own cycle
  always_comb begin
    if (state_q == FS_IDLE) begin
      req_region = sw_req_i ? region_d : REG_NONE;
      we_o       = sw_we_i;
      index_o    = index_d;
      word_o     = word_d;
      wdata_o    = sw_wdata_i;
    end else begin
      req_region = (state_q == FS_WAIT_GRANT) ? region_q : REG_NONE;
      we_o       = we_q;
      index_o    = index_q;
      word_o     = word_q;
      wdata_o    = wdata_q;
    end
  end

  assign dat_req_o = (req_region == REG_DAT);
  assign dct_req_o = (req_region == REG_DCT);
  assign granted   = dat_gnt_i || dct_gnt_i;

  // Unmapped accesses answer by themselves one cycle after the request
  assign sw_ack_o   = (state_q == FS_WAIT_ACK) &&
                      (region_q == REG_NONE || rd_ack_i || wr_ack_i);
  assign sw_rdata_o = (state_q == FS_WAIT_ACK && rd_ack_i) ? rdata_i : '0;

  always_comb begin
    state_d = state_q;
    case (state_q)
      FS_IDLE: begin
        if (sw_req_i) begin
          state_d = (region_d != REG_NONE && !granted) ? FS_WAIT_GRANT : FS_WAIT_ACK;
        end
      end
      FS_WAIT_GRANT: begin
        if (granted) begin
          state_d = FS_WAIT_ACK;
        end
      end
      FS_WAIT_ACK: begin
        if (sw_ack_o) begin
          state_d = FS_IDLE;
        end
      end
      default: state_d = FS_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= FS_IDLE;
      region_q <= REG_NONE;
    end else begin
      state_q <= state_d;
      if (state_q == FS_IDLE && sw_req_i) begin
        region_q <= region_d;
      end
    end
  end

  // Held copy of the access while it waits behind hardware
  always_ff @(posedge clk_i) begin
    if (state_q == FS_IDLE && sw_req_i) begin
      we_q    <= sw_we_i;
      index_q <= index_d;
      word_q  <= word_d;
      wdata_q <= sw_wdata_i;
    end
  end

  // Bus master must wait for sw_ack_o before the next request
  one_outstanding_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    sw_req_i |-> state_q == FS_IDLE);

endmodule

`default_nettype wire

// ==== hdl/table_ram.sv ====
// Contents power up undefined; rdata_o keeps the last read entry and is not updated by writes
`timescale 1ns/1ps
`default_nettype none

module table_ram #(
  parameter int unsigned AW = i3c_table_pkg::DAT_AW,
  parameter int unsigned DW = i3c_table_pkg::DAT_DW
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          req_i,
  input  logic          we_i,
  input  logic [AW-1:0] addr_i,
  input  logic [DW-1:0] wdata_i,
  input  logic [DW-1:0] wmask_i,
  output logic [DW-1:0] rdata_o
);

  logic [DW-1:0] mem_q [2**AW];

  // Bit-granular write, untouched bits keep their old value
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      mem_q[addr_i] <= (mem_q[addr_i] & ~wmask_i) | (wdata_i & wmask_i);
    end
  end

  // One-cycle read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (req_i && !we_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

  // Either requester driving an X index would corrupt or misread an entry
  addr_known_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i |-> !$isunknown(addr_i));

endmodule

`default_nettype wire

// ==== i3c_tables_top.f ====
hdl/i3c_table_pkg.sv
hdl/i3c_csr_pkg.sv
hdl/table_ram.sv
hdl/table_csr_front.sv
hdl/dev_tables.sv
hdl/i3c_tables_top.sv
verif/tb_i3c_tables.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
  -f i3c_tables_top.f --top-module tb_i3c_tables -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0

// ==== verif/tb_i3c_tables.sv ====
// Needs Verilator --timing and --assert; every table entry is written before it is first read
`timescale 1ns/1ps
`default_nettype none

module tb_i3c_tables;
  import i3c_table_pkg::*;
  import i3c_csr_pkg::*;

  logic clk_i, rst_ni;
  logic dat_rd_i, dct_rd_i, dct_wr_i;
  logic [DAT_AW-1:0] dat_idx_i;
  logic [DCT_AW-1:0] dct_idx_i;
  logic [DAT_DW-1:0] dat_rdata_o;
  logic [DCT_DW-1:0] dct_wdata_i, dct_rdata_o;
  logic sw_req_i, sw_we_i, sw_ack_o;
  logic [SW_AW-1:0] sw_addr_i;
  logic [SW_DW-1:0] sw_wdata_i, sw_rdata_o;

  // Shadow copies of both tables
  logic [DAT_DW-1:0] dat_model [2**DAT_AW];
  logic [DCT_DW-1:0] dct_model [2**DCT_AW];
  logic [31:0] lfsr_q;
  logic [SW_DW-1:0] sw_exp;
  logic sw_chk_rd, sw_started;
  logic dat_chk_v, dct_chk_v;
  logic [DAT_DW-1:0] dat_chk_exp;
  logic [DCT_DW-1:0] dct_chk_exp;
  int rst_errs, sw_errs, dat_errs, dct_errs, timeouts;
  int sw_checks, hw_checks;

  i3c_tables_top uut (.*);

  always #4 clk_i = ~clk_i;

  // Expected entry of a hardware read, taken at the edge that samples it
  always @(posedge clk_i) begin
    dat_chk_v   <= dat_rd_i;
    dct_chk_v   <= dct_rd_i;
    dat_chk_exp <= dat_model[dat_idx_i];
    dct_chk_exp <= dct_model[dct_idx_i];
    if (dat_rd_i || dct_rd_i) begin
      hw_checks++;
    end
  end

  // Checks run mid-cycle where every output has settled
  reset_idle_a: assert property (@(negedge clk_i) disable iff (!rst_ni)
    !sw_started |-> !sw_ack_o && sw_rdata_o == '0)
    else begin
      rst_errs++;
      $display("ERR sw_ack_o %h sw_rdata_o %h before first request", sw_ack_o, sw_rdata_o);
    end

  sw_rdata_a: assert property (@(negedge clk_i) disable iff (!rst_ni)
    sw_ack_o && sw_chk_rd |-> sw_rdata_o == sw_exp)
    else begin
      sw_errs++;
      $display("ERR sw_rdata_o addr %h got %h exp %h", sw_addr_i, sw_rdata_o, sw_exp);
    end

  dat_rdata_a: assert property (@(negedge clk_i) disable iff (!rst_ni)
    dat_chk_v |-> dat_rdata_o == dat_chk_exp)
    else begin
      dat_errs++;
      $display("ERR dat_rdata_o got %h exp %h", dat_rdata_o, dat_chk_exp);
    end

  dct_rdata_a: assert property (@(negedge clk_i) disable iff (!rst_ni)
    dct_chk_v |-> dct_rdata_o == dct_chk_exp)
    else begin
      dct_errs++;
      $display("ERR dct_rdata_o got %h exp %h", dct_rdata_o, dct_chk_exp);
    end

  // Galois LFSR, one step per bit handed out
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  function automatic logic [DAT_AW-1:0] rand_idx();
    return DAT_AW'(take_bits(DAT_AW));
  endfunction

  function automatic logic [SW_AW-1:0] dat_addr(input logic [DAT_AW-1:0] idx, input logic w);
    return DAT_BASE | {2'b00, idx, w, 2'b00};
  endfunction

  function automatic logic [SW_AW-1:0] dct_addr(input logic [DCT_AW-1:0] idx,
                                                input logic [1:0] w);
    return DCT_BASE | {1'b0, idx, w, 2'b00};
  endfunction

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic sw_start(input logic we, input logic [SW_AW-1:0] addr,
                          input logic [SW_DW-1:0] wdata, input logic [SW_DW-1:0] exp);
    sw_exp     = exp;
    sw_chk_rd  = !we;
    sw_started = 1'b1;
    sw_req_i   = 1'b1;
    sw_we_i    = we;
    sw_addr_i  = addr;
    sw_wdata_i = wdata;
  endtask

  task automatic wait_sw_ack();
    bit seen;
    seen = 1'b0;
    for (int n = 0; n < 50 && !seen; n++) begin
      @(negedge clk_i);
      seen = sw_ack_o;
    end
    if (!seen) begin
      timeouts++;
      $display("Timeout: no software ack within 50 cycles for address %h", sw_addr_i);
    end else if (sw_chk_rd) begin
      sw_checks++;
    end
  endtask

  task automatic sw_access(input logic we, input logic [SW_AW-1:0] addr,
                           input logic [SW_DW-1:0] wdata, input logic [SW_DW-1:0] exp);
    next_cycle();
    sw_start(we, addr, wdata, exp);
    next_cycle();
    sw_req_i = 1'b0;
    wait_sw_ack();
  endtask

  // Model follows only once the write is acked
  task automatic dat_sw_write(input logic [DAT_AW-1:0] idx, input logic w,
                              input logic [SW_DW-1:0] data);
    sw_access(1'b1, dat_addr(idx, w), data, '0);
    dat_model[idx][w*SW_DW +: SW_DW] = data;
  endtask

  task automatic dat_hw_read(input logic [DAT_AW-1:0] idx);
    next_cycle();
    dat_rd_i  = 1'b1;
    dat_idx_i = idx;
    next_cycle();
    dat_rd_i  = 1'b0;
  endtask

  task automatic dct_hw_read(input logic [DCT_AW-1:0] idx);
    next_cycle();
    dct_rd_i  = 1'b1;
    dct_idx_i = idx;
    next_cycle();
    dct_rd_i  = 1'b0;
  endtask

  task automatic dct_hw_write(input logic [DCT_AW-1:0] idx, input logic [DCT_DW-1:0] data);
    next_cycle();
    dct_wr_i    = 1'b1;
    dct_idx_i   = idx;
    dct_wdata_i = data;
    dct_model[idx] = data;
    next_cycle();
    dct_wr_i    = 1'b0;
  endtask

  // Software read raced by a burst of hardware reads to the same table
  task automatic collide(input logic on_dct);
    logic [DAT_AW-1:0] idx;
    logic [1:0] w;
    int hold;
    idx  = rand_idx();
    w    = on_dct ? 2'(take_bits(2)) : 2'(take_bits(1));
    hold = int'(take_bits(2)) + 1;
    next_cycle();
    if (on_dct) begin
      sw_start(1'b0, dct_addr(idx, w), '0, dct_model[idx][w*SW_DW +: SW_DW]);
    end else begin
      sw_start(1'b0, dat_addr(idx, w[0]), '0, dat_model[idx][w[0]*SW_DW +: SW_DW]);
    end
    for (int c = 0; c <= hold; c++) begin
      dat_rd_i  = !on_dct;
      dct_rd_i  = on_dct;
      dat_idx_i = rand_idx();
      dct_idx_i = rand_idx();
      next_cycle();
      sw_req_i  = 1'b0;
    end
    dat_rd_i = 1'b0;
    dct_rd_i = 1'b0;
    wait_sw_ack();
  endtask

  initial begin
    logic [DAT_AW-1:0] idx;
    logic [1:0] w;
    logic [SW_DW-1:0] data;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    {dat_rd_i, dct_rd_i, dct_wr_i, sw_req_i, sw_we_i} = '0;
    dat_idx_i = '0;
    dct_idx_i = '0;
    dct_wdata_i = '0;
    sw_addr_i = '0;
    sw_wdata_i = '0;
    lfsr_q = 32'h4e76_2bc7;
    {sw_exp, sw_chk_rd, sw_started} = '0;
    {rst_errs, sw_errs, dat_errs, dct_errs, timeouts, sw_checks, hw_checks} = '0;
    repeat (8) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    repeat (4) next_cycle();

    for (int i = 0; i < 2**DAT_AW; i++) begin
      dct_hw_write(DCT_AW'(i), {take_bits(32), take_bits(32), take_bits(32), take_bits(32)});
      dat_sw_write(DAT_AW'(i), 1'b0, take_bits(32));
      dat_sw_write(DAT_AW'(i), 1'b1, take_bits(32));
    end
    // Single-word DAT writes, both words read back, then the whole entry
    for (int i = 0; i < 16; i++) begin
      idx = rand_idx();
      w = 2'(take_bits(1));
      dat_sw_write(idx, w[0], take_bits(32));
      sw_access(1'b0, dat_addr(idx, 1'b0), '0, dat_model[idx][31:0]);
      sw_access(1'b0, dat_addr(idx, 1'b1), '0, dat_model[idx][63:32]);
      dat_hw_read(idx);
    end
    for (int i = 0; i < 8; i++) begin
      idx = rand_idx();
      dct_hw_write(idx, {take_bits(32), take_bits(32), take_bits(32), take_bits(32)});
      for (int k = 0; k < DCT_WORDS; k++) begin
        sw_access(1'b0, dct_addr(idx, 2'(k)), '0, dct_model[idx][k*SW_DW +: SW_DW]);
      end
      dct_hw_read(idx);
    end
    // DCT is read-only to software
    for (int i = 0; i < 8; i++) begin
      idx = rand_idx();
      w = 2'(take_bits(2));
      sw_access(1'b1, dct_addr(idx, w), take_bits(32), '0);
      sw_access(1'b0, dct_addr(idx, w), '0, dct_model[idx][w*SW_DW +: SW_DW]);
      dct_hw_read(idx);
    end
    for (int i = 0; i < 8; i++) begin
      collide(1'b0);
      collide(1'b1);
    end
    data = take_bits(32);
    sw_access(1'b1, 12'h500, data, '0);
    sw_access(1'b0, 12'h500, '0, '0);
    sw_access(1'b0, 12'h7fc, '0, '0);
    // Final sweep catches any entry that changed behind the model
    for (int i = 0; i < 2**DAT_AW; i++) begin
      dat_hw_read(DAT_AW'(i));
      dct_hw_read(DCT_AW'(i));
    end
    repeat (2) next_cycle();

    $display("Errors: reset %0d, sw read %0d, dat %0d, dct %0d, timeout %0d; checks sw %0d hw %0d",
             rst_errs, sw_errs, dat_errs, dct_errs, timeouts, sw_checks, hw_checks);
    if (rst_errs + sw_errs + dat_errs + dct_errs + timeouts == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire
